// File: logic/rv_isa_pkg.sv
// ****************************************
// RISC-V ISA definitions
// Opcodes, funct3 codes and trap causes
// used by the memory-access stage, plus
// the word, PC and cause types.
// ****************************************

package rv_isa_pkg;

    // Data word as held in registers and RAM.
    typedef logic [31:0] word_t;
    // Instruction address, halfword granular.
    typedef logic [31:1] pc_t;
    // Raw instruction word.
    typedef logic [31:0] insn_t;
    // Trap cause code.
    typedef logic [3:0]  cause_t;

    // Major opcodes, insn[6:2].
    localparam logic [4:0] op_load  = 5'b00000;
    localparam logic [4:0] op_store = 5'b01000;

    // Access size and sign, insn[14:12].
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    // Zero-extending loads.
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    // Misaligned access causes.
    localparam cause_t cause_load_misaligned  = 4'd4;
    localparam cause_t cause_store_misaligned = 4'd6;

endpackage

// File: logic/mem_bus_pkg.sv
// ****************************************
// Memory bus definitions
// RAM sizes, bus request and the EX/MEM
// and MEM/WB barrier structs.
// ****************************************

package mem_bus_pkg;

    // RAM depth in words.
    localparam int ram_words = 256;
    // Byte lanes per bus word.
    localparam int bus_lanes = 4;

    // Word address into the RAM.
    typedef logic [$clog2(ram_words)-1:0] waddr_t;
    // One write enable per byte lane.
    typedef logic [bus_lanes-1:0] bmask_t;

    // Single-cycle bus request.
    typedef struct packed {
        logic              re;
        logic              we;
        waddr_t            waddr;
        rv_isa_pkg::word_t wdata;
        bmask_t            wmask;
    } mem_req_t;

    // EX/MEM barrier.
    typedef struct packed {
        logic                valid;
        rv_isa_pkg::pc_t     pc;
        rv_isa_pkg::insn_t   insn;
        logic                use_rd;
        // ALU result, also the memory address.
        rv_isa_pkg::word_t   rs1_val;
        // Store data.
        rv_isa_pkg::word_t   rs2_val;
        logic                trap;
        rv_isa_pkg::cause_t  cause;
    } ex_mem_t;

    // MEM/WB barrier.
    typedef struct packed {
        logic                valid;
        rv_isa_pkg::pc_t     pc;
        rv_isa_pkg::insn_t   insn;
        logic                use_rd;
        rv_isa_pkg::word_t   rd_val;
        logic                trap;
        rv_isa_pkg::cause_t  cause;
    } mem_wb_t;

endpackage

// File: logic/data_ram.sv
// ****************************************
// Data RAM
// Single-ported synchronous RAM with byte
// write enables and a registered read.
// ****************************************

`timescale 1ns/1ps

module data_ram (
    input  logic                  clk,
    input  mem_bus_pkg::mem_req_t req,
    output rv_isa_pkg::word_t     rdata
);
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;

    // Storage array.
    word_t mem [ram_words];

    // Byte-lane writes at the end of the granted cycle.
    always_ff @(posedge clk) begin
        if (req.we) begin
            for (int i = 0; i < bus_lanes; i++) begin
                if (req.wmask[i]) begin
                    mem[req.waddr][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    // Read data appears the cycle after the strobe.
    // Held until the next read.
    always_ff @(posedge clk) begin
        if (req.re) begin
            rdata <= mem[req.waddr];
        end
    end

endmodule

// File: logic/bus_arbiter.sv
// ****************************************
// Memory bus arbiter
// Fixed priority, data side over fetch.
// Steers read data back to whichever
// master owned the previous cycle's read.
// ****************************************

`timescale 1ns/1ps

module bus_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_bus_pkg::mem_req_t data_req,
    input  mem_bus_pkg::mem_req_t fetch_req,
    output mem_bus_pkg::mem_req_t ram_req,
    input  rv_isa_pkg::word_t     ram_rdata,
    output logic                  grant_fetch,
    output rv_isa_pkg::word_t     data_rdata,
    output rv_isa_pkg::word_t     fetch_rdata,
    output logic                  fetch_rdata_valid
);
    // Data side has a strobe this cycle.
    logic data_sel;
    // Fetch gets the bus.
    logic fetch_sel;
    // Owner of last cycle's read.
    logic read_data;
    logic read_fetch;

    assign data_sel  = data_req.re || data_req.we;
    assign fetch_sel = !data_sel && (fetch_req.re || fetch_req.we);

    // Idle cycles pass the strobe-free fetch request.
    assign ram_req     = data_sel ? data_req : fetch_req;
    assign grant_fetch = fetch_sel;

    // Remember who issued the read.
    always_ff @(posedge clk) begin
        if (rst) begin
            read_data  <= 1'b0;
            read_fetch <= 1'b0;
        end else begin
            read_data  <= data_sel && data_req.re;
            read_fetch <= fetch_sel && fetch_req.re;
        end
    end

    // Return path.
    // Non-owner sees zero.
    assign data_rdata        = read_data ? ram_rdata : '0;
    assign fetch_rdata       = read_fetch ? ram_rdata : '0;
    assign fetch_rdata_valid = read_fetch;

endmodule

// File: logic/mem_lane_align.sv
// ****************************************
// Memory lane alignment
// Alignment check, store lane placement
// and write mask, load lane extraction
// with sign or zero extension.
// ****************************************

`timescale 1ns/1ps

module mem_lane_align (
    input  logic [2:0]          funct3,
    input  rv_isa_pkg::word_t   addr,
    input  rv_isa_pkg::word_t   store_val,
    input  rv_isa_pkg::word_t   ram_word,
    output logic                misaligned,
    output rv_isa_pkg::word_t   wdata,
    output mem_bus_pkg::bmask_t wmask,
    output rv_isa_pkg::word_t   load_val
);
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;

    // Byte offset within the word.
    logic [1:0]  lane;
    // Selected load lanes.
    logic [7:0]  load_byte;
    logic [15:0] load_half;

    assign lane = addr[1:0];

    // Natural alignment per access size.
    always_comb begin
        case (funct3)
            f3_byte, f3_byte_u: misaligned = 1'b0;
            f3_half, f3_half_u: misaligned = lane[0];
            default:            misaligned = |lane;
        endcase
    end

    // Store data is copied to every lane.
    // The mask picks the lanes that are written.
    always_comb begin
        case (funct3)
            f3_byte: begin
                wdata = {4{store_val[7:0]}};
                wmask = bmask_t'(1) << lane;
            end
            f3_half: begin
                wdata = {2{store_val[15:0]}};
                wmask = bmask_t'(3) << {lane[1], 1'b0};
            end
            default: begin
                wdata = store_val;
                wmask = '1;
            end
        endcase
    end

    // Lane select for loads.
    assign load_byte = ram_word[{lane, 3'b000} +: 8];
    assign load_half = lane[1] ? ram_word[31:16] : ram_word[15:0];

    // Extension by funct3.
    always_comb begin
        case (funct3)
            f3_byte:   load_val = {{24{load_byte[7]}}, load_byte};
            f3_byte_u: load_val = {24'b0, load_byte};
            f3_half:   load_val = {{16{load_half[15]}}, load_half};
            f3_half_u: load_val = {16'b0, load_half};
            default:   load_val = ram_word;
        endcase
    end

endmodule

// File: logic/mem_stage.sv
// ****************************************
// MEM pipeline stage
// EX/MEM barrier register, load wait FSM,
// bus request generation and MEM/WB
// outputs with misaligned access traps.
// ****************************************

`timescale 1ns/1ps

module mem_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  stall,
    input  mem_bus_pkg::ex_mem_t  d,
    output mem_bus_pkg::mem_wb_t  q,
    output logic                  busy,
    output mem_bus_pkg::mem_req_t bus_req,
    input  rv_isa_pkg::word_t     bus_rdata
);
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic {
        stage_idle,
        stage_load_wait
    } stage_state_t;

    // Barrier contents.
    ex_mem_t      r;
    stage_state_t state;
    // Barrier already spent its first cycle.
    logic         issued;
    logic         capture;
    logic         is_load;
    logic         is_store;
    // Valid entry without an upstream trap.
    logic         live;
    logic         misaligned;
    logic         mis_trap;
    logic         issue_load;
    logic         issue_store;
    word_t        wdata;
    word_t        load_val;
    bmask_t       wmask;

    assign capture = !stall && !busy;

    // Pipeline barrier register.
    always_ff @(posedge clk) begin
        if (rst) begin
            r.valid <= 1'b0;
            r.trap  <= 1'b0;
        end else if (capture) begin
            r <= d;
        end
    end

    // Cleared on capture, set once the barrier is held.
    always_ff @(posedge clk) begin
        if (rst) begin
            issued <= 1'b0;
        end else begin
            issued <= !capture;
        end
    end

    // Decode.
    assign is_load  = r.insn[6:2] == op_load;
    assign is_store = r.insn[6:2] == op_store;
    assign live     = r.valid && !r.trap;

    mem_lane_align u_align (
        .funct3     (r.insn[14:12]),
        .addr       (r.rs1_val),
        .store_val  (r.rs2_val),
        .ram_word   (bus_rdata),
        .misaligned (misaligned),
        .wdata      (wdata),
        .wmask      (wmask),
        .load_val   (load_val)
    );

    assign mis_trap = live && (is_load || is_store) && misaligned;

    // Loads have no side effects, so a held load reads again.
    // Stores go out once per capture.
    assign issue_load  = (state == stage_idle) && live && is_load && !misaligned && !clear;
    assign issue_store = live && is_store && !misaligned && !issued && !clear;
    assign busy        = issue_load;

    // Bus request.
    always_comb begin
        bus_req.re    = issue_load;
        bus_req.we    = issue_store;
        bus_req.waddr = r.rs1_val[2 +: $bits(waddr_t)];
        bus_req.wdata = wdata;
        bus_req.wmask = wmask;
    end

    // Load wait FSM.
    // Wait lasts one cycle, a clear simply blocks the next issue.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stage_idle;
        end else begin
            case (state)
                stage_idle: begin
                    if (issue_load) begin
                        state <= stage_load_wait;
                    end
                end
                default: state <= stage_idle;
            endcase
        end
    end

    // MEM/WB outputs.
    // Upstream cause wins over the local one.
    always_comb begin
        q.valid  = r.valid && !r.trap && !mis_trap && !issue_load && !clear;
        q.pc     = r.pc;
        q.insn   = r.insn;
        q.use_rd = r.use_rd;
        q.rd_val = (state == stage_load_wait) ? load_val : r.rs1_val;
        q.trap   = (r.trap || mis_trap) && !clear;
        if (r.trap) begin
            q.cause = r.cause;
        end else if (is_load) begin
            q.cause = cause_load_misaligned;
        end else begin
            q.cause = cause_store_misaligned;
        end
    end

endmodule

// File: logic/fetch_port.sv
// ****************************************
// Instruction fetch port
// Holds one fetch until the arbiter
// grants it, then returns the word.
// ****************************************

`timescale 1ns/1ps

module fetch_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fetch_req,
    input  rv_isa_pkg::pc_t       fetch_addr,
    output logic                  busy,
    input  logic                  grant,
    output mem_bus_pkg::mem_req_t bus_req,
    input  rv_isa_pkg::word_t     bus_rdata,
    input  logic                  rdata_valid,
    output logic                  fetch_valid,
    output rv_isa_pkg::insn_t     fetch_insn
);
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_pending,
        fetch_wait
    } fetch_state_t;

    fetch_state_t state;
    // Latched word address.
    waddr_t       addr_q;

    // Accept, request until granted, then wait for data.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch_idle;
        end else begin
            case (state)
                fetch_idle:    if (fetch_req) state <= fetch_pending;
                fetch_pending: if (grant) state <= fetch_wait;
                default:       if (rdata_valid) state <= fetch_idle;
            endcase
        end
    end

    // Word address taken on acceptance.
    always_ff @(posedge clk) begin
        if (state == fetch_idle && fetch_req) begin
            addr_q <= fetch_addr[2 +: $bits(waddr_t)];
        end
    end

    assign busy = state != fetch_idle;

    // Read-only master.
    always_comb begin
        bus_req.re    = state == fetch_pending;
        bus_req.we    = 1'b0;
        bus_req.waddr = addr_q;
        bus_req.wdata = '0;
        bus_req.wmask = '0;
    end

    // Word returns the cycle after the grant.
    assign fetch_valid = (state == fetch_wait) && rdata_valid;
    assign fetch_insn  = bus_rdata;

endmodule

// File: logic/mem_subsystem.sv
// ****************************************
// Memory subsystem top level
// MEM stage and fetch port sharing one
// data RAM through the bus arbiter.
// ****************************************

`timescale 1ns/1ps

module mem_subsystem (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clear,
    input  logic                 stall,
    input  mem_bus_pkg::ex_mem_t ex_mem,
    output mem_bus_pkg::mem_wb_t mem_wb,
    output logic                 busy,
    input  logic                 fetch_req,
    input  rv_isa_pkg::pc_t      fetch_addr,
    output logic                 fetch_busy,
    output logic                 fetch_valid,
    output rv_isa_pkg::insn_t    fetch_insn
);
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;

    // Master requests and the granted one.
    mem_req_t data_req;
    mem_req_t fetch_bus_req;
    mem_req_t ram_req;
    // Read return paths.
    word_t    ram_rdata;
    word_t    data_rdata;
    word_t    fetch_rdata;
    logic     fetch_rdata_valid;
    logic     grant_fetch;

    mem_stage u_stage (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .stall     (stall),
        .d         (ex_mem),
        .q         (mem_wb),
        .busy      (busy),
        .bus_req   (data_req),
        .bus_rdata (data_rdata)
    );

    fetch_port u_fetch (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .busy        (fetch_busy),
        .grant       (grant_fetch),
        .bus_req     (fetch_bus_req),
        .bus_rdata   (fetch_rdata),
        .rdata_valid (fetch_rdata_valid),
        .fetch_valid (fetch_valid),
        .fetch_insn  (fetch_insn)
    );

    bus_arbiter u_arb (
        .clk               (clk),
        .rst               (rst),
        .data_req          (data_req),
        .fetch_req         (fetch_bus_req),
        .ram_req           (ram_req),
        .ram_rdata         (ram_rdata),
        .grant_fetch       (grant_fetch),
        .data_rdata        (data_rdata),
        .fetch_rdata       (fetch_rdata),
        .fetch_rdata_valid (fetch_rdata_valid)
    );

    data_ram u_ram (
        .clk   (clk),
        .req   (ram_req),
        .rdata (ram_rdata)
    );

endmodule

// File: test/tb_mem_subsystem.sv
// ****************************************
// Memory subsystem testbench
// Replays load/store cases from a file,
// injects random fetches and checks them
// against a shadow memory.
// ****************************************

`timescale 1ns/1ps

module tb_mem_subsystem;
    import rv_isa_pkg::*;
    import mem_bus_pkg::*;

    // Columns per case line.
    localparam int case_cols = 7;
    localparam int max_cases = 64;
    // Cycle budget per case.
    localparam int cycle_limit = 20;
    // Cycles a stalled store is held.
    localparam int hold_cycles = 3;
    // OP-IMM opcode for pass-through entries.
    localparam logic [4:0] op_imm = 5'b00100;

    logic    clk;
    logic    rst;
    logic    clear;
    logic    stall;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    logic    busy;
    logic    fetch_req;
    pc_t     fetch_addr;
    logic    fetch_busy;
    logic    fetch_valid;
    insn_t   fetch_insn;

    // Raw case table.
    word_t       case_mem [max_cases*case_cols];
    // Expected RAM contents.
    word_t       shadow [ram_words];
    // Words written whole, safe to fetch.
    waddr_t      known [$];
    // Fetches still in flight.
    waddr_t      fetch_q [$];
    logic [31:0] lfsr;
    int          n_cases;
    int          errors;

    mem_subsystem DUT (
        .clk        (clk),
        .rst        (rst),
        .clear      (clear),
        .stall      (stall),
        .ex_mem     (ex_mem),
        .mem_wb     (mem_wb),
        .busy       (busy),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_busy (fetch_busy),
        .fetch_valid(fetch_valid),
        .fetch_insn (fetch_insn)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken.
    task automatic draw_bits(input int n, output int unsigned v);
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | lfsr[0];
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Store rule: only the addressed lanes change.
    task automatic apply_store(input word_t addr, input logic [2:0] f3, input word_t data);
        waddr_t wa;
        logic   found;
        wa = addr[2 +: $bits(waddr_t)];
        found = 1'b0;
        case (f3)
            f3_byte: shadow[wa][8*addr[1:0] +: 8] = data[7:0];
            f3_half: shadow[wa][16*addr[1] +: 16] = data[15:0];
            default: begin
                shadow[wa] = data;
                foreach (known[k]) begin
                    if (known[k] == wa) found = 1'b1;
                end
                if (!found) known.push_back(wa);
            end
        endcase
    endtask

    task automatic run_case(input int i);
        word_t       kind;
        word_t       addr;
        word_t       data;
        word_t       expect_rd;
        word_t       flags;
        logic [2:0]  f3;
        logic [4:0]  opcode;
        cause_t      exp_cause;
        logic        is_store;
        logic        exp_trap;
        logic        exp_valid;
        logic        exp_wait;
        int unsigned inject;
        int unsigned pick;
        int          cycles;
        int          n_hold;
        int          errs_before;
        waddr_t      wa;
        word_t       ba;
        ex_mem_t     entry;
        mem_wb_t     held;

        kind      = case_mem[i*case_cols];
        f3        = case_mem[i*case_cols+1][2:0];
        addr      = case_mem[i*case_cols+2];
        data      = case_mem[i*case_cols+3];
        expect_rd = case_mem[i*case_cols+4];
        exp_cause = case_mem[i*case_cols+5][3:0];
        flags     = case_mem[i*case_cols+6];
        is_store  = kind == 2;
        // Any cause means a trap unless clear kills it.
        exp_trap  = exp_cause != 0 && !flags[0];
        exp_valid = !exp_trap && !flags[0];
        exp_wait  = kind == 1 && exp_valid;
        errs_before = errors;
        opcode = (kind == 1) ? op_load : (is_store ? op_store : op_imm);

        entry         = '0;
        entry.valid   = 1'b1;
        entry.pc      = pc_t'(i * 4);
        entry.insn    = {17'b0, f3, 5'b0, opcode, 2'b11};
        entry.use_rd  = !is_store;
        entry.rs1_val = addr;
        entry.rs2_val = data;
        entry.trap    = flags[2];
        entry.cause   = flags[2] ? exp_cause : '0;

        // Fetch injection, decided while the port is idle.
        // A stalled store always gets a fetch to compete with.
        @(negedge clk);
        cycles = 0;
        while (flags[1] && fetch_busy === 1'b1 && cycles < cycle_limit) begin
            @(negedge clk);
            cycles++;
        end
        draw_bits(1, inject);
        if ((inject == 1 || flags[1]) && fetch_busy === 1'b0 && known.size() > 0) begin
            inject = 1;
            draw_bits(8, pick);
            wa = known[pick % known.size()];
        end else begin
            inject = 0;
        end
        @(posedge clk);
        ex_mem <= entry;
        if (inject == 1) begin
            ba = {22'b0, wa, 2'b00};
            fetch_req  <= 1'b1;
            fetch_addr <= ba[31:1];
            fetch_q.push_back(wa);
        end
        // Barrier takes the entry here; a bubble follows.
        @(posedge clk);
        ex_mem    <= '0;
        fetch_req <= 1'b0;
        clear     <= flags[0];
        stall     <= flags[1];

        @(negedge clk);
        check_value("busy", busy, exp_wait);
        if (inject == 1) check_value("fetch_busy", fetch_busy, 1'b1);
        if (exp_wait) begin
            cycles = 0;
            while (busy === 1'b1 && cycles < cycle_limit) begin
                @(negedge clk);
                cycles++;
            end
            assert (cycles == 1) else
                report_failure($sformatf("load held busy for %0d cycles", cycles));
            // Fetch cannot have owned the bus in the load's read cycle.
            assert (fetch_valid !== 1'b1) else
                report_failure("fetch completed in the cycle after a data read");
        end
        check_value("mem_wb.valid", mem_wb.valid, exp_valid);
        check_value("mem_wb.trap", mem_wb.trap, exp_trap);
        if (exp_trap) check_value("mem_wb.cause", mem_wb.cause, exp_cause);
        if (exp_valid && !is_store) check_value("mem_wb.rd_val", mem_wb.rd_val, expect_rd);
        // Barrier fields pass through unchanged.
        check_value("mem_wb.pc", mem_wb.pc, entry.pc);
        check_value("mem_wb.insn", mem_wb.insn, entry.insn);
        check_value("mem_wb.use_rd", mem_wb.use_rd, entry.use_rd);
        held = mem_wb;

        // RAM write lands on this edge.
        @(posedge clk);
        if (is_store && exp_valid) apply_store(addr, f3, data);
        n_hold = flags[1] ? hold_cycles : ((is_store && exp_valid) ? 1 : 0);
        for (int h = 0; h < n_hold; h++) begin
            @(negedge clk);
            if (h == 0 && is_store && exp_valid) begin
                assert (fetch_valid !== 1'b1) else
                    report_failure("fetch completed in the cycle after a data write");
            end
            // A repeated store would keep the fetch off the bus.
            if (h == 1 && flags[1] && is_store && exp_valid && inject == 1) begin
                assert (fetch_valid === 1'b1) else
                    report_failure("fetch blocked while the stalled store was held");
            end
            if (flags[1]) begin
                assert (mem_wb === held) else begin
                    $display("mismatch mem_wb: got %h, expected %h", mem_wb, held);
                    errors++;
                end
            end
            @(posedge clk);
        end
        clear <= 1'b0;
        stall <= 1'b0;
        $display("case %0d: %s", i, (errors == errs_before) ? "ok" : "error");
    endtask

    // Fetch responses against the shadow memory.
    always @(negedge clk) begin : fetch_monitor
        waddr_t wa;
        if (rst === 1'b0 && fetch_valid === 1'b1) begin
            assert (fetch_q.size() > 0) else
                report_failure("fetch returned a word with no request pending");
            if (fetch_q.size() > 0) begin
                wa = fetch_q.pop_front();
                check_value("fetch_insn", fetch_insn, shadow[wa]);
            end
        end
    end

    // Watchdog scaled by the case count.
    initial begin
        @(negedge rst);
        repeat (n_cases * cycle_limit + 50) @(posedge clk);
        $display("timeout after %0d cases worth of cycles", n_cases);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int cycles;
        rst        = 1'b1;
        clear      = 1'b0;
        stall      = 1'b0;
        ex_mem     = '0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        errors     = 0;
        n_cases    = 0;
        lfsr       = 32'h1b5f_eedd;
        $readmemh("test/mem_cases.txt", case_mem);
        while (n_cases < max_cases && !$isunknown(case_mem[n_cases*case_cols])) begin
            n_cases++;
        end
        assert (n_cases > 0) else report_failure("no cases read from the case file");
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < n_cases; i++) begin
            run_case(i);
        end

        // Let outstanding fetches drain.
        cycles = 0;
        while ((fetch_busy === 1'b1 || fetch_q.size() > 0) && cycles < cycle_limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (fetch_q.size() == 0) else
            report_failure("fetch requests left without a response");
        check_value("fetch_busy", fetch_busy, 1'b0);

        $display("cases %0d, failed checks %0d", n_cases, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
logic/rv_isa_pkg.sv
logic/mem_bus_pkg.sv
logic/data_ram.sv
logic/bus_arbiter.sv
logic/mem_lane_align.sv
logic/mem_stage.sv
logic/fetch_port.sv
logic/mem_subsystem.sv
test/tb_mem_subsystem.sv

// File: test/mem_cases.txt
// kind (0 alu, 1 load, 2 store), funct3, address, store data, expected rd_val,
// expected trap cause (0 none), flags (1 clear, 2 stall, 4 upstream trap)
2 2 00000100 12345678 00000000 0 0
1 2 00000100 00000000 12345678 0 0
2 2 00000104 80f07f01 00000000 0 0
1 0 00000104 00000000 00000001 0 0
1 0 00000105 00000000 0000007f 0 0
1 0 00000106 00000000 fffffff0 0 0
1 4 00000107 00000000 00000080 0 0
1 0 00000107 00000000 ffffff80 0 0
1 1 00000106 00000000 ffff80f0 0 0
1 5 00000106 00000000 000080f0 0 0
1 1 00000104 00000000 00007f01 0 0
2 0 00000101 000000aa 00000000 0 0
2 1 00000102 0000beef 00000000 0 0
1 2 00000100 00000000 beefaa78 0 0
1 1 00000101 00000000 00000000 4 0
1 2 00000102 00000000 00000000 4 0
2 2 00000103 ffffffff 00000000 6 0
2 1 00000105 0000ffff 00000000 6 0
1 2 00000104 00000000 80f07f01 0 0
1 5 00000102 00000000 0000beef 0 0
1 2 00000108 00000000 00000000 2 4
0 0 deadbeef 00000000 deadbeef 0 0
0 0 0badf00d 00000000 00000000 0 1
2 2 00000100 00000000 00000000 0 1
1 2 00000100 00000000 beefaa78 0 0
2 2 00000108 cafef00d 00000000 0 2
1 2 00000108 00000000 cafef00d 0 0
2 2 0000010a 00000000 00000000 5 4
2 0 0000010b 0000005a 00000000 0 0
1 2 00000108 00000000 5afef00d 0 0
1 4 0000010b 00000000 0000005a 0 0
